//--- common/heapOpsPkg.sv
// Operation encodings for the array heap
// Action codes and error codes

package heapOpsPkg;

  //----------------------------------------------------------------------
  // Actions, numbered as in the original heap, 0 is idle
  //----------------------------------------------------------------------
  typedef enum logic [7:0] {
    actIdle     = 8'd0,                                   // Nothing to do
    actClear    = 8'd1,                                   // Drop every allocation
    actWrite    = 8'd2,                                   // Write an element
    actRead     = 8'd3,                                   // Read an element
    actSize     = 8'd4,                                   // Current size of array
    actPush     = 8'd14,                                  // Append to array
    actPop      = 8'd15,                                  // Remove last element
    actAlloc    = 8'd18,                                  // Take an array from the pool
    actFree     = 8'd19,                                  // Return an array to the pool
    actAdd      = 8'd20,                                  // Add, new value out
    actAddAfter = 8'd21,                                  // Add, old value out
    actSubtract = 8'd22,                                  // Subtract, new value out
    actSubAfter = 8'd23,                                  // Subtract, old value out
    actOr       = 8'd28,                                  // Bitwise or
    actXor      = 8'd29,                                  // Bitwise xor
    actAnd      = 8'd30                                   // Bitwise and
  } heapAction_e;

  //----------------------------------------------------------------------
  // Error codes
  //----------------------------------------------------------------------
  typedef enum logic [2:0] {
    errNone,                                              // Action accepted
    errNotAllocated,                                      // Array never handed out
    errFreed,                                             // Array handed back
    errOutOfBounds,                                       // Index at or past size
    errFull,                                              // Push on full array
    errEmpty,                                             // Pop on empty array
    errOutOfMemory,                                       // No array left
    errBadAction                                          // Unknown action code
  } heapError_e;

endpackage

//--- common/heapTypesPkg.sv
// Data shapes for the array heap
// Width typedefs, request, command and response structs

`include "heap_settings.svh"

package heapTypesPkg;

  typedef logic [`HEAP_ADDRESS_BITS-1:0] arrayNum_t;     // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0]   elemIndex_t;    // Element index
  typedef logic [`HEAP_INDEX_BITS:0]     arraySize_t;    // Size, full array fits
  typedef logic [`HEAP_DATA_BITS-1:0]    heapData_t;     // Element value

  //----------------------------------------------------------------------
  // Buses between the outside and the heap stages
  //----------------------------------------------------------------------
  typedef struct packed {
    heapOpsPkg::heapAction_e action;                      // What to do
    arrayNum_t               array;                       // Array to act on
    elemIndex_t              index;                       // Element within array
    heapData_t               data;                        // Operand
  } heapRequest_t;

  typedef struct packed {
    heapRequest_t           request;                      // Request, targets resolved
    heapOpsPkg::heapError_e error;                        // Outcome of the checks
  } heapCommand_t;

  typedef struct packed {
    heapData_t              value;                        // Last returned value
    heapOpsPkg::heapError_e error;                        // Last error code
  } heapResponse_t;

endpackage

//--- common/heap_settings.svh
// Width macros for the array heap
// Derived array count and length, watchdog margin

`ifndef HEAP_SETTINGS_SVH
`define HEAP_SETTINGS_SVH

`define HEAP_ADDRESS_BITS    2                            // Bits in an array number
`define HEAP_INDEX_BITS      3                            // Bits in an element index
`define HEAP_DATA_BITS      12                            // Width of one element

`define HEAP_ARRAYS         (1 << `HEAP_ADDRESS_BITS)     // Arrays in the pool
`define HEAP_LENGTH         (1 << `HEAP_INDEX_BITS)       // Elements per array

`define HEAP_TIMEOUT_MARGIN 200                           // Extra cycles for the watchdog

`endif

//--- dv/heapVectors.svh
// Directed table for the array heap testbench
// Columns: action, array, index, data, expected value, expected error, value checked

`ifndef HEAP_VECTORS_SVH
`define HEAP_VECTORS_SVH

task automatic buildTable();
  addVector(actIdle,     0, 0, 'h000, 'h000, errNone,         1); // Response right after reset
  //----------------------------------------------------------------------
  // Fresh allocation, then out of memory
  //----------------------------------------------------------------------
  addVector(actAlloc,    0, 0, 'h000, 'h000, errNone,         1);
  addVector(actAlloc,    0, 0, 'h000, 'h001, errNone,         1);
  addVector(actAlloc,    0, 0, 'h000, 'h002, errNone,         1);
  addVector(actAlloc,    0, 0, 'h000, 'h003, errNone,         1);
  addVector(actAlloc,    0, 0, 'h000, 'h003, errOutOfMemory,  1); // Old value stays
  addVector(actIdle,     0, 0, 'h000, 'h003, errOutOfMemory,  1); // Idle holds response
  //----------------------------------------------------------------------
  // Free and reuse
  //----------------------------------------------------------------------
  addVector(actFree,     1, 0, 'h000, 'h000, errNone,         0);
  addVector(actRead,     1, 0, 'h000, 'h000, errFreed,        0);
  addVector(actWrite,    1, 0, 'h055, 'h000, errFreed,        0);
  addVector(actAlloc,    0, 0, 'h000, 'h001, errNone,         1); // Freed array comes back
  //----------------------------------------------------------------------
  // Size growth and bounds
  //----------------------------------------------------------------------
  addVector(actSize,     1, 0, 'h000, 'h000, errNone,         1);
  addVector(actWrite,    1, 4, 'h5A5, 'h5A5, errNone,         1);
  addVector(actSize,     1, 0, 'h000, 'h005, errNone,         1);
  addVector(actRead,     1, 5, 'h000, 'h000, errOutOfBounds,  0);
  addVector(actRead,     1, 4, 'h000, 'h5A5, errNone,         1);
  //----------------------------------------------------------------------
  // Stack access
  //----------------------------------------------------------------------
  addVector(actPop,      2, 0, 'h000, 'h000, errEmpty,        0);
  addVector(actPush,     2, 0, 'h123, 'h000, errNone,         0);
  addVector(actPop,      2, 0, 'h000, 'h123, errNone,         1);
  addVector(actSize,     2, 0, 'h000, 'h000, errNone,         1);
  addVector(actWrite,    3, 7, 'hFFF, 'hFFF, errNone,         1); // Fills array 3
  addVector(actPush,     3, 0, 'h001, 'h000, errFull,         0);
  addVector(actSize,     3, 0, 'h000, 'h008, errNone,         1);
  addVector(actPop,      3, 0, 'h000, 'hFFF, errNone,         1);
  addVector(actSize,     3, 0, 'h000, 'h007, errNone,         1);
  //----------------------------------------------------------------------
  // Element arithmetic on array 0
  //----------------------------------------------------------------------
  addVector(actWrite,    0, 0, 'h100, 'h100, errNone,         1);
  addVector(actAdd,      0, 0, 'h023, 'h123, errNone,         1);
  addVector(actAddAfter, 0, 0, 'h010, 'h123, errNone,         1); // Old value, now 133
  addVector(actRead,     0, 0, 'h000, 'h133, errNone,         1);
  addVector(actSubtract, 0, 0, 'h033, 'h100, errNone,         1);
  addVector(actSubAfter, 0, 0, 'h101, 'h100, errNone,         1); // Wraps below zero
  addVector(actRead,     0, 0, 'h000, 'hFFF, errNone,         1);
  addVector(actAdd,      0, 0, 'h002, 'h001, errNone,         1); // Wraps past the top
  addVector(actOr,       0, 0, 'h0F0, 'h0F1, errNone,         1);
  addVector(actXor,      0, 0, 'h0FF, 'h00E, errNone,         1);
  addVector(actAnd,      0, 0, 'h00C, 'h00C, errNone,         1);
  addVector(actRead,     0, 0, 'h000, 'h00C, errNone,         1);
  addVector(actAdd,      0, 1, 'h001, 'h000, errOutOfBounds,  0);
  addVector(heapAction_e'(8'd5), 0, 0, 'h000, 'h000, errBadAction, 0); // Dropped action code
  //----------------------------------------------------------------------
  // Clear
  //----------------------------------------------------------------------
  addVector(actClear,    0, 0, 'h000, 'h000, errNone,         0);
  addVector(actRead,     0, 0, 'h000, 'h000, errNotAllocated, 0);
  addVector(actSize,     2, 0, 'h000, 'h000, errNotAllocated, 0);
  addVector(actFree,     3, 0, 'h000, 'h000, errNotAllocated, 0);
  addVector(actAlloc,    0, 0, 'h000, 'h000, errNone,         1); // Numbering restarts
endtask

`endif

//--- dv/heapMemoryTb.sv
// Testbench for the array heap
// Directed table, seeded random arithmetic against a model, watchdog

`timescale 1ns/10ps
`include "heap_settings.svh"

module heapMemoryTb;
  import heapOpsPkg::*;
  import heapTypesPkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int RANDOM_COUNT = 60;                       // Random arithmetic steps
  localparam int SETUP_COUNT  = 1 + `HEAP_ARRAYS + `HEAP_ARRAYS * `HEAP_LENGTH;

  typedef struct packed {
    heapRequest_t request;
    heapData_t    value;                                  // Expected response value
    heapError_e   error;                                  // Expected response error
    logic         careValue;                              // Zero when value is don't-care
  } vector_t;

  logic          clock;
  logic          reset;
  heapRequest_t  request;
  heapResponse_t response;

  vector_t   vectors[$];                                  // Directed table
  heapData_t model [`HEAP_ARRAYS][`HEAP_LENGTH];          // Expected element contents
  integer    seed;
  int        stepCount;
  int        passCount;
  int        failCount;

  heapMemory DUT (
    .clock    (clock),
    .reset    (reset),
    .request  (request),
    .response (response)
  );

  task automatic addVector(input heapAction_e action, input int array, input int index,
                           input int data, input int value, input heapError_e error,
                           input bit careValue);
    vector_t entry;
    entry.request.action = action;
    entry.request.array  = arrayNum_t'(array);
    entry.request.index  = elemIndex_t'(index);
    entry.request.data   = heapData_t'(data);
    entry.value          = heapData_t'(value);
    entry.error          = error;
    entry.careValue      = careValue;
    vectors.push_back(entry);
  endtask

  `include "heapVectors.svh"

  //----------------------------------------------------------------------
  // One action, entered at edge plus 5 ns, checked one cycle later
  //----------------------------------------------------------------------
  task automatic runStep(input heapRequest_t stepRequest, input heapData_t expValue,
                         input heapError_e expError, input bit careValue);
    bit stepOk;
    stepOk  = 1'b1;
    request = stepRequest;
    @(posedge clock);
    #5;                                                   // Response settled after edge
    assert (response.error == expError) else begin
      $display("[ERROR] step %0d response.error expected %h got %h",
               stepCount, expError, response.error);
      stepOk = 1'b0;
    end
    if (careValue) begin
      assert (response.value == expValue) else begin
        $display("[ERROR] step %0d response.value expected %h got %h",
                 stepCount, expValue, response.value);
        stepOk = 1'b0;
      end
    end
    if (stepOk) passCount++;
    else failCount++;
    $display("step %0d action %0d array %0d index %0d: %s", stepCount, stepRequest.action,
             stepRequest.array, stepRequest.index, stepOk ? "ok" : "mismatch");
    stepCount++;
  endtask

  //----------------------------------------------------------------------
  // Fill every array, then random Write, Add, Xor and Read
  //----------------------------------------------------------------------
  task automatic randomPhase();
    heapRequest_t stepRequest;
    heapData_t    expValue;
    logic [31:0]  pick;
    int           a;
    int           i;
    stepRequest        = '0;
    stepRequest.action = actClear;
    runStep(stepRequest, '0, errNone, 1'b0);
    stepRequest.action = actAlloc;
    for (a = 0; a < `HEAP_ARRAYS; a++) begin
      runStep(stepRequest, heapData_t'(a), errNone, 1'b1); // Fresh numbers in order
    end
    stepRequest.action = actWrite;
    for (a = 0; a < `HEAP_ARRAYS; a++) begin
      for (i = 0; i < `HEAP_LENGTH; i++) begin
        stepRequest.array = arrayNum_t'(a);
        stepRequest.index = elemIndex_t'(i);
        stepRequest.data  = heapData_t'($random(seed));
        model[a][i]       = stepRequest.data;
        runStep(stepRequest, stepRequest.data, errNone, 1'b1);
      end
    end
    repeat (RANDOM_COUNT) begin
      pick              = $random(seed);
      stepRequest.array = arrayNum_t'(pick);
      stepRequest.index = elemIndex_t'(pick >> 8);
      stepRequest.data  = heapData_t'(pick >> 16);
      a = stepRequest.array;
      i = stepRequest.index;
      case (pick[31:30])
        2'd0: begin
          stepRequest.action = actWrite;
          model[a][i]        = stepRequest.data;
        end
        2'd1: begin
          stepRequest.action = actAdd;
          model[a][i]        = model[a][i] + stepRequest.data; // Modulo element width
        end
        2'd2: begin
          stepRequest.action = actXor;
          model[a][i]        = model[a][i] ^ stepRequest.data;
        end
        default: stepRequest.action = actRead;
      endcase
      expValue = model[a][i];
      runStep(stepRequest, expValue, errNone, 1'b1);
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;                           // 40 ns period
  end

  initial begin
    seed      = 32'h6217e2fd;
    stepCount = 0;
    passCount = 0;
    failCount = 0;
    reset     = 1'b1;
    request   = '0;                                       // Idle
    buildTable();
    repeat (RESET_CYCLES) @(posedge clock);
    #5;
    reset = 1'b0;
    foreach (vectors[n]) begin
      runStep(vectors[n].request, vectors[n].value, vectors[n].error, vectors[n].careValue);
    end
    randomPhase();
    request = '0;
    $display("steps %0d passed %0d failed %0d", stepCount, passCount, failCount);
    if (failCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog sized from reset, table, random phase and margin
  initial begin
    #1;
    repeat (RESET_CYCLES + vectors.size() + SETUP_COUNT + RANDOM_COUNT
            + `HEAP_TIMEOUT_MARGIN) @(posedge clock);
    $display("Timeout: the run did not finish within the allowed number of cycles");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- heap/heapDecode.sv
// Heap action decoder
// Checks allocation, bounds, full, empty and memory state
// Resolves push, pop and alloc targets into the command

`timescale 1ns/10ps
`include "heap_settings.svh"

module heapDecode (
  input  heapTypesPkg::heapRequest_t                    request,
  input  heapTypesPkg::arraySize_t [`HEAP_ARRAYS-1:0]   sizes,
  input  logic [`HEAP_ARRAYS-1:0]                       allocated,
  input  heapTypesPkg::arraySize_t                      freeTop,
  input  heapTypesPkg::arraySize_t                      freshNext,
  input  heapTypesPkg::arrayNum_t                       freeHead,
  output heapTypesPkg::heapCommand_t                    command
);
  import heapOpsPkg::*;
  import heapTypesPkg::*;

  arraySize_t size;                                       // Size of addressed array
  heapError_e writeError;                                 // Result of writable check
  heapError_e readError;                                  // Writable plus bounds
  logic       full;
  logic       empty;
  logic       outOfMemory;

  assign size        = sizes[request.array];
  assign full        = size == arraySize_t'(`HEAP_LENGTH);
  assign empty       = size == '0;
  assign outOfMemory = (freeTop == '0) && (freshNext == arraySize_t'(`HEAP_ARRAYS));

  //----------------------------------------------------------------------
  // Array checks, never handed out wins over freed
  //----------------------------------------------------------------------
  always_comb begin
    if (arraySize_t'(request.array) >= freshNext) begin
      writeError = errNotAllocated;
    end else if (!allocated[request.array]) begin
      writeError = errFreed;
    end else begin
      writeError = errNone;
    end
  end

  always_comb begin
    if (writeError != errNone) begin
      readError = writeError;
    end else if (arraySize_t'(request.index) >= size) begin
      readError = errOutOfBounds;                         // Past current size
    end else begin
      readError = errNone;
    end
  end

  //----------------------------------------------------------------------
  // Per action outcome
  //----------------------------------------------------------------------
  always_comb begin
    command.request = request;                            // Pass through by default
    command.error   = errNone;
    case (request.action)
      actIdle, actClear: ;                                // Always accepted
      actWrite, actSize, actFree: begin
        command.error = writeError;
      end
      actRead, actAdd, actAddAfter, actSubtract, actSubAfter, actOr, actXor, actAnd: begin
        command.error = readError;
      end
      actPush: begin
        command.request.index = size[`HEAP_INDEX_BITS-1:0]; // Slot after the last
        if (writeError != errNone) begin
          command.error = writeError;
        end else if (full) begin
          command.error = errFull;
        end
      end
      actPop: begin
        command.request.index = elemIndex_t'(size - 1'b1); // Last element
        if (writeError != errNone) begin
          command.error = writeError;
        end else if (empty) begin
          command.error = errEmpty;
        end
      end
      actAlloc: begin
        if (freeTop != '0) begin
          command.request.array = freeHead;               // Most recently freed first
        end else begin
          command.request.array = freshNext[`HEAP_ADDRESS_BITS-1:0];
        end
        if (outOfMemory) begin
          command.error = errOutOfMemory;
        end
      end
      default: command.error = errBadAction;
    endcase
  end

endmodule

//--- heap/heapExecute.sv
// Heap state and action execution
// Element storage, sizes, allocation flags, free stack, fresh counter
// Combinational return value for the current command

`timescale 1ns/10ps
`include "heap_settings.svh"

module heapExecute (
  input  logic                                          clock,
  input  logic                                          reset,
  input  heapTypesPkg::heapCommand_t                    command,
  output heapTypesPkg::arraySize_t [`HEAP_ARRAYS-1:0]   sizes,
  output logic [`HEAP_ARRAYS-1:0]                       allocated,
  output heapTypesPkg::arraySize_t                      freeTop,
  output heapTypesPkg::arraySize_t                      freshNext,
  output heapTypesPkg::arrayNum_t                       freeHead,
  output heapTypesPkg::heapData_t                       value
);
  import heapOpsPkg::*;
  import heapTypesPkg::*;

  heapData_t   memory    [`HEAP_ARRAYS][`HEAP_LENGTH];   // Fixed block per array
  arrayNum_t   freeStack [`HEAP_ARRAYS];                 // Freed array numbers

  heapAction_e action;
  arrayNum_t   array;
  elemIndex_t  index;
  heapData_t   data;
  heapData_t   element;                                   // Addressed element now
  heapData_t   combined;                                  // Element after the action
  arrayNum_t   headSlot;                                  // Top entry of free stack
  logic        accepted;                                  // Passed every check
  logic        elementWrite;

  assign action   = command.request.action;
  assign array    = command.request.array;
  assign index    = command.request.index;
  assign data     = command.request.data;
  assign accepted = command.error == errNone;
  assign element  = memory[array][index];
  assign headSlot = freeTop[`HEAP_ADDRESS_BITS-1:0] - 1'b1; // Wraps to last slot when full
  assign freeHead = freeStack[headSlot];

  //----------------------------------------------------------------------
  // Element arithmetic and return value
  //----------------------------------------------------------------------
  always_comb begin
    case (action)
      actAdd, actAddAfter:      combined = element + data;
      actSubtract, actSubAfter: combined = element - data;
      actOr:                    combined = element | data;
      actXor:                   combined = element ^ data;
      actAnd:                   combined = element & data;
      default:                  combined = data;          // Write and push store operand
    endcase
  end

  always_comb begin
    case (action)
      actWrite:                              value = data;
      actSize:                               value = heapData_t'(sizes[array]);
      actAlloc:                              value = heapData_t'(array);
      actRead, actPop, actAddAfter, actSubAfter: value = element; // Before the update
      default:                               value = combined;
    endcase
  end

  always_comb begin
    case (action)
      actWrite, actPush, actAdd, actAddAfter, actSubtract, actSubAfter,
      actOr, actXor, actAnd: elementWrite = accepted;
      default:               elementWrite = 1'b0;
    endcase
  end

  //----------------------------------------------------------------------
  // Storage
  //----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (elementWrite) begin
      memory[array][index] <= combined;
    end
  end

  always_ff @(posedge clock) begin
    if (accepted && action == actFree) begin
      freeStack[freeTop[`HEAP_ADDRESS_BITS-1:0]] <= array; // Push onto free stack
    end
  end

  //----------------------------------------------------------------------
  // Allocation state and sizes
  //----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset || (accepted && action == actClear)) begin
      sizes     <= '0;
      allocated <= '0;                                    // Nothing handed out
      freeTop   <= '0;
      freshNext <= '0;
    end else if (accepted) begin
      case (action)
        actWrite: begin
          if (arraySize_t'(index) >= sizes[array]) begin
            sizes[array] <= arraySize_t'(index) + 1'b1;   // Grow to cover index
          end
        end
        actPush: sizes[array] <= sizes[array] + 1'b1;
        actPop:  sizes[array] <= sizes[array] - 1'b1;
        actAlloc: begin
          allocated[array] <= 1'b1;
          sizes[array]     <= '0;                         // Starts empty
          if (freeTop != '0) begin
            freeTop <= freeTop - 1'b1;                    // Reuse freed array
          end else begin
            freshNext <= freshNext + 1'b1;                // Take a new one
          end
        end
        actFree: begin
          allocated[array] <= 1'b0;
          freeTop          <= freeTop + 1'b1;
        end
        default: ;
      endcase
    end
  end

  // Free stack never holds more than the pool
  freeTopBound: assert property (@(posedge clock) disable iff (reset)
    freeTop <= arraySize_t'(`HEAP_ARRAYS));

  // Decode must keep element updates off arrays that are not handed out
  freedUntouched: assert property (@(posedge clock) disable iff (reset)
    elementWrite |-> allocated[array]);

endmodule

//--- heap/heapMemory.sv
// Array heap top level
// Decode, execute and response stages

`timescale 1ns/10ps
`include "heap_settings.svh"

module heapMemory (
  input  logic                        clock,
  input  logic                        reset,
  input  heapTypesPkg::heapRequest_t  request,
  output heapTypesPkg::heapResponse_t response
);
  import heapTypesPkg::*;

  arraySize_t [`HEAP_ARRAYS-1:0] sizes;                   // Size of every array
  logic       [`HEAP_ARRAYS-1:0] allocated;               // Allocation flags
  arraySize_t                    freeTop;                 // Free stack depth
  arraySize_t                    freshNext;               // Next never used array
  arrayNum_t                     freeHead;                // Top of free stack
  heapCommand_t                  command;                 // Checked request
  heapData_t                     value;                   // Value of current action

  heapDecode decode (
    .request   (request),
    .sizes     (sizes),
    .allocated (allocated),
    .freeTop   (freeTop),
    .freshNext (freshNext),
    .freeHead  (freeHead),
    .command   (command)
  );

  heapExecute execute (
    .clock     (clock),
    .reset     (reset),
    .command   (command),
    .sizes     (sizes),
    .allocated (allocated),
    .freeTop   (freeTop),
    .freshNext (freshNext),
    .freeHead  (freeHead),
    .value     (value)
  );

  heapResult result (
    .clock     (clock),
    .reset     (reset),
    .command   (command),
    .value     (value),
    .response  (response)
  );

endmodule

//--- heap/heapResult.sv
// Heap response register
// Value loads on accepted returning actions, error on every action

`timescale 1ns/10ps

module heapResult (
  input  logic                        clock,
  input  logic                        reset,
  input  heapTypesPkg::heapCommand_t  command,
  input  heapTypesPkg::heapData_t     value,
  output heapTypesPkg::heapResponse_t response
);
  import heapOpsPkg::*;
  import heapTypesPkg::*;

  logic returning;                                        // Action hands back a value

  always_comb begin
    case (command.request.action)
      actIdle, actClear, actFree, actPush: returning = 1'b0; // Error only
      default:                             returning = 1'b1;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      response.value <= '0;
      response.error <= errNone;
    end else if (command.request.action != actIdle) begin
      response.error <= command.error;                    // Every real action reports
      if (command.error == errNone && returning) begin
        response.value <= value;                          // Old value kept on error
      end
    end
  end

endmodule

//--- tb.f
+incdir+common
+incdir+dv
common/heapOpsPkg.sv
common/heapTypesPkg.sv
heap/heapDecode.sv
heap/heapExecute.sv
heap/heapResult.sv
heap/heapMemory.sv
dv/heapMemoryTb.sv
